/* tb.f */
verilog/rv_data_pkg.sv
verilog/exu_op_pkg.sv
verilog/md_if.sv
verilog/alu_adder.sv
verilog/alu_shifter.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/exu_ctrl.sv
verilog/exu_top.sv
verification/exu_chk.sv
verification/exu_tb.sv

/* verification/exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_tb;

  logic                         clk;
  logic                         rst_n;
  logic [4:0]                   op;
  logic                         md_en;
  logic                         flush;
  logic [rv_data_pkg::XLEN-1:0] src1;
  logic [rv_data_pkg::XLEN-1:0] src2;
  logic [rv_data_pkg::XLEN-1:0] result;
  logic                         less;
  logic                         zero;
  logic                         not_ok;
  logic [31:0]                  rng_state;

  logic [rv_data_pkg::XLEN-1:0] corner [8] = '{64'd0, '1, 64'h8000_0000_0000_0000, 64'd1,
    64'h7fff_ffff_ffff_ffff, 64'h0000_0000_8000_0000, 64'hffff_ffff_7fff_ffff, 64'd2};
  logic [5:0] shift_amt [4] = '{6'd0, 6'd31, 6'd32, 6'd63};
  string mul_name [4] = '{"mul", "mulh", "mulhsu", "mulhu"};
  string div_name [4] = '{"div", "divu", "rem", "remu"};

  exu_top exu_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_i     (op),
    .md_en_i  (md_en),
    .flush_i  (flush),
    .src1_i   (src1),
    .src2_i   (src2),
    .result_o (result),
    .less_o   (less),
    .zero_o   (zero),
    .not_ok_o (not_ok)
  );

  bind exu_ctrl exu_chk exu_chk_inst (
    .clk (clk), .rst_n (rst_n), .md_en_i (md_en_i), .flush_i (flush_i),
    .op_i (op_i), .src1_i (src1_i), .src2_i (src2_i), .start_i (start_q),
    .done_i (md.mul_done | md.div_done), .lock_op_i (lock_op),
    .lock_src1_i (lock_src1), .lock_src2_i (lock_src2), .not_ok_i (not_ok_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (exu_top_inst.exu_ctrl_inst.exu_chk_inst.fail_cnt != 0) begin
      $display("concurrent assertion in exu_chk failed");
      fail_now();
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // roughly one operand in three is a corner value
  function automatic logic [63:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[2:0] < 3'd3) return corner[r[5:3]];
    return {next_rand(), next_rand()};
  endfunction

  function automatic logic [4:0] alu_op(input logic word, input logic alt, input logic [2:0] fn);
    return {word, alt, fn};
  endfunction

  function automatic logic [63:0] model_alu(input logic [4:0] op_w, input logic [63:0] a,
                                            input logic [63:0] b);
    logic        word;
    logic        alt;
    logic [31:0] w;
    logic [63:0] r;
    word = op_w[4];
    alt  = op_w[3];
    case (op_w[2:0])
      exu_op_pkg::FN_ADD:  r = alt ? a - b : a + b;
      exu_op_pkg::FN_SLL:  r = word ? {32'd0, a[31:0] << b[4:0]} : a << b[5:0];
      exu_op_pkg::FN_SLT: begin
        if (alt) r = {63'd0, a < b};
        else r = {63'd0, $signed(a) < $signed(b)};
      end
      exu_op_pkg::FN_PASS: r = b;
      exu_op_pkg::FN_XOR:  r = a ^ b;
      exu_op_pkg::FN_SR: begin
        if (word && alt) w = $signed(a[31:0]) >>> b[4:0];
        else w = a[31:0] >> b[4:0];
        if (word) r = {32'd0, w};
        else if (alt) r = $signed(a) >>> b[5:0];
        else r = a >> b[5:0];
      end
      exu_op_pkg::FN_OR:   r = a | b;
      default:             r = a & b;
    endcase
    // word results take bit 31 as sign
    if (word) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [63:0] model_md(input logic is_div, input logic [1:0] kind,
                                           input logic [63:0] a, input logic [63:0] b);
    logic [127:0] ax;
    logic [127:0] bx;
    logic [127:0] p;
    logic [63:0]  q;
    logic [63:0]  r;
    logic         sgn;
    if (!is_div) begin
      // sign-extended operands give the signed product modulo 2^128
      ax = (kind == exu_op_pkg::MULH || kind == exu_op_pkg::MULHSU) ? {{64{a[63]}}, a} : {64'd0, a};
      bx = (kind == exu_op_pkg::MULH) ? {{64{b[63]}}, b} : {64'd0, b};
      p  = ax * bx;
      return (kind == exu_op_pkg::MUL) ? p[63:0] : p[127:64];
    end
    sgn = (kind == exu_op_pkg::DIV) || (kind == exu_op_pkg::REM);
    if (b == 64'd0) begin
      q = '1;
      r = a;
    end else if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) begin
      q = a;
      r = 64'd0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return (kind == exu_op_pkg::DIV || kind == exu_op_pkg::DIVU) ? q : r;
  endfunction

  task automatic fail_now();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_now();
    end
  endtask

  task automatic wait_ready(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (not_ok !== 1'b0) begin
      if (cycles == 300) begin
        $display("%s: mul/div unit never finished, stall still high", name);
        fail_now();
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic run_alu(input string name, input logic [4:0] op_w, input logic [63:0] a,
                         input logic [63:0] b);
    logic [63:0] exp;
    logic [63:0] sum;
    exp   = model_alu(op_w, a, b);
    sum   = op_w[3] ? a - b : a + b;
    op    = op_w;
    md_en = 1'b0;
    src1  = a;
    src2  = b;
    @(negedge clk);
    check_eq(name, exp, result);
    if (op_w[2:0] == exu_op_pkg::FN_ADD) check_eq({name, " zero"}, {63'd0, sum == 0}, {63'd0, zero});
    if (op_w[2:0] == exu_op_pkg::FN_SLT) check_eq({name, " less"}, {63'd0, exp[0]}, {63'd0, less});
  endtask

  task automatic run_md(input string name, input logic is_div, input logic [1:0] kind,
                        input logic [63:0] a, input logic [63:0] b);
    logic [63:0] exp;
    exp   = model_md(is_div, kind, a, b);
    op    = {2'b00, is_div, kind};
    md_en = 1'b1;
    src1  = a;
    src2  = b;
    wait_ready(name);
    check_eq(name, exp, result);
    // result must hold while the request stays the same
    repeat (3) begin
      @(negedge clk);
      check_eq({name, " hold"}, exp, result);
      check_eq({name, " stall"}, 64'd0, {63'd0, not_ok});
    end
  endtask

  initial begin
    logic [63:0] a;
    logic [63:0] b;
    rst_n     = 1'b0;
    op        = 5'd0;
    md_en     = 1'b0;
    flush     = 1'b0;
    src1      = '0;
    src2      = '0;
    rng_state = 32'he6c8_1ba0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < 40; i++) begin
      a = pick_operand();
      b = pick_operand();
      run_alu("add", alu_op(1'b0, 1'b0, exu_op_pkg::FN_ADD), a, b);
      run_alu("sub", alu_op(1'b0, 1'b1, exu_op_pkg::FN_ADD), a, b);
      run_alu("addw", alu_op(1'b1, 1'b0, exu_op_pkg::FN_ADD), a, b);
      run_alu("subw", alu_op(1'b1, 1'b1, exu_op_pkg::FN_ADD), a, b);
      run_alu("sub equal", alu_op(1'b0, 1'b1, exu_op_pkg::FN_ADD), a, a);
      run_alu("xor", alu_op(1'b0, 1'b0, exu_op_pkg::FN_XOR), a, b);
      run_alu("or", alu_op(1'b0, 1'b0, exu_op_pkg::FN_OR), a, b);
      run_alu("and", alu_op(1'b0, 1'b0, exu_op_pkg::FN_AND), a, b);
      run_alu("pass", alu_op(1'b0, 1'b0, exu_op_pkg::FN_PASS), a, b);
      run_alu("slt", alu_op(1'b0, 1'b0, exu_op_pkg::FN_SLT), a, b);
      run_alu("sltu", alu_op(1'b0, 1'b1, exu_op_pkg::FN_SLT), a, b);
    end
    // sign bits differ
    run_alu("slt mixed", alu_op(1'b0, 1'b0, exu_op_pkg::FN_SLT), 64'h8000_0000_0000_0000, 64'd1);
    run_alu("sltu mixed", alu_op(1'b0, 1'b1, exu_op_pkg::FN_SLT), 64'h8000_0000_0000_0000, 64'd1);

    for (int i = 0; i < 20; i++) begin
      for (int k = 0; k < 5; k++) begin
        a = pick_operand();
        b = pick_operand();
        if (k < 4) b[5:0] = shift_amt[k];
        run_alu("sll", alu_op(1'b0, 1'b0, exu_op_pkg::FN_SLL), a, b);
        run_alu("srl", alu_op(1'b0, 1'b0, exu_op_pkg::FN_SR), a, b);
        run_alu("sra", alu_op(1'b0, 1'b1, exu_op_pkg::FN_SR), a, b);
        run_alu("sllw", alu_op(1'b1, 1'b0, exu_op_pkg::FN_SLL), a, b);
        run_alu("srlw", alu_op(1'b1, 1'b0, exu_op_pkg::FN_SR), a, b);
        run_alu("sraw", alu_op(1'b1, 1'b1, exu_op_pkg::FN_SR), a, b);
      end
    end

    for (int i = 0; i < 10; i++) begin
      a = pick_operand();
      b = pick_operand();
      for (int k = 0; k < 4; k++) run_md(mul_name[k], 1'b0, 2'(k), a, b);
      for (int k = 0; k < 4; k++) run_md(div_name[k], 1'b1, 2'(k), a, b);
    end
    for (int k = 0; k < 4; k++) begin
      run_md({div_name[k], " by zero"}, 1'b1, 2'(k), pick_operand(), 64'd0);
      run_md({div_name[k], " min by -1"}, 1'b1, 2'(k), 64'h8000_0000_0000_0000, '1);
    end

    // flush in the middle of a divide, then new operands
    op    = {2'b00, 1'b1, exu_op_pkg::DIV};
    md_en = 1'b1;
    src1  = pick_operand();
    src2  = 64'd7;
    repeat (10) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    run_md("divu after flush", 1'b1, exu_op_pkg::DIVU, pick_operand(), pick_operand());

    // new operands while the multiplier is still busy
    op   = {2'b00, 1'b0, exu_op_pkg::MULH};
    src1 = pick_operand();
    src2 = pick_operand();
    repeat (10) @(negedge clk);
    run_md("mulhu changed operands", 1'b0, exu_op_pkg::MULHU, pick_operand(), pick_operand());

    md_en = 1'b0;
    repeat (2) @(negedge clk);
    if (exu_top_inst.exu_ctrl_inst.exu_chk_inst.fail_cnt != 0) begin
      $display("concurrent assertions in exu_chk failed");
      fail_now();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verification/exu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_chk (
  input wire logic                         clk,
  input wire logic                         rst_n,
  input wire logic                         md_en_i,
  input wire logic                         flush_i,
  input wire logic [4:0]                   op_i,
  input wire logic [rv_data_pkg::XLEN-1:0] src1_i,
  input wire logic [rv_data_pkg::XLEN-1:0] src2_i,
  input wire logic                         start_i,
  input wire logic                         done_i,
  input wire logic [4:0]                   lock_op_i,
  input wire logic [rv_data_pkg::XLEN-1:0] lock_src1_i,
  input wire logic [rv_data_pkg::XLEN-1:0] lock_src2_i,
  input wire logic                         not_ok_i
);

  // failed assertion count
  int fail_cnt = 0;

  start_pulse: assert property (@(posedge clk) disable iff (!rst_n) start_i |=> !start_i)
    else begin
      $error("start stayed high for more than one cycle");
      fail_cnt++;
    end

  no_stall_alu: assert property (@(posedge clk) disable iff (!rst_n) !md_en_i |-> !not_ok_i)
    else begin
      $error("stall raised without a mul/div request");
      fail_cnt++;
    end

  // request unchanged since the lock, so the result has to be ready
  done_clears_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (done_i && !flush_i) |=> (!not_ok_i || (op_i != lock_op_i) ||
                              (src1_i != lock_src1_i) || (src2_i != lock_src2_i)))
    else begin
      $error("stall still high after the unit finished");
      fail_cnt++;
    end

  reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> (!not_ok_i && !start_i))
    else begin
      $error("stall or start active right after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* verilog/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic [4:0]                   op_i,
  input  wire logic                         md_en_i,
  input  wire logic                         flush_i,
  input  wire logic [rv_data_pkg::XLEN-1:0] src1_i,
  input  wire logic [rv_data_pkg::XLEN-1:0] src2_i,
  output logic [rv_data_pkg::XLEN-1:0]      result_o,
  output logic                              less_o,
  output logic                              zero_o,
  output logic                              not_ok_o
);

  exu_op_pkg::exu_op_u          op_u;
  logic                         add_sub;
  logic                         is_unsigned;
  logic                         sr_arith;
  logic                         sr_right;
  logic [rv_data_pkg::XLEN-1:0] sum;
  logic [rv_data_pkg::XLEN-1:0] shift;

  md_if md ();

  assign op_u = exu_op_pkg::exu_op_u'(op_i);

  exu_ctrl exu_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_i       (op_u),
    .md_en_i    (md_en_i),
    .flush_i    (flush_i),
    .src1_i     (src1_i),
    .src2_i     (src2_i),
    .add_sub_o  (add_sub),
    .unsigned_o (is_unsigned),
    .sr_arith_o (sr_arith),
    .sr_right_o (sr_right),
    .sum_i      (sum),
    .shift_i    (shift),
    .less_i     (less_o),
    .md         (md.ctrl),
    .result_o   (result_o),
    .not_ok_o   (not_ok_o)
  );

  alu_adder alu_adder_inst (
    .src1_i     (src1_i),
    .src2_i     (src2_i),
    .add_sub_i  (add_sub),
    .unsigned_i (is_unsigned),
    .sum_o      (sum),
    .zero_o     (zero_o),
    .less_o     (less_o)
  );

  alu_shifter alu_shifter_inst (
    .src1_i  (src1_i),
    .shamt_i (src2_i[rv_data_pkg::SHAMT_W-1:0]),
    .word_i  (op_u.alu.word),
    .right_i (sr_right),
    .arith_i (sr_arith),
    .shift_o (shift)
  );

  mul_unit mul_unit_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .md    (md.mul)
  );

  div_unit div_unit_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .md    (md.div)
  );

endmodule

`default_nettype wire

/* verilog/exu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire exu_op_pkg::exu_op_u          op_i,
  input  wire logic                         md_en_i,
  input  wire logic                         flush_i,
  input  wire logic [rv_data_pkg::XLEN-1:0] src1_i,
  input  wire logic [rv_data_pkg::XLEN-1:0] src2_i,
  output logic                              add_sub_o,
  output logic                              unsigned_o,
  output logic                              sr_arith_o,
  output logic                              sr_right_o,
  input  wire logic [rv_data_pkg::XLEN-1:0] sum_i,
  input  wire logic [rv_data_pkg::XLEN-1:0] shift_i,
  input  wire logic                         less_i,
  md_if.ctrl                                md,
  output logic [rv_data_pkg::XLEN-1:0]      result_o,
  output logic                              not_ok_o
);

  exu_op_pkg::alu_op_t          alu_op;
  exu_op_pkg::exu_op_u          lock_op;
  logic [rv_data_pkg::XLEN-1:0] lock_src1;
  logic [rv_data_pkg::XLEN-1:0] lock_src2;
  logic                         lock_vld;
  logic                         busy;
  logic                         start_q;
  logic                         hit;
  logic                         issue;
  logic [rv_data_pkg::XLEN-1:0] alu_res;
  logic [rv_data_pkg::XLEN-1:0] md_res;

  // alu view of the op word only without a mul/div request
  assign alu_op = md_en_i ? '0 : op_i.alu;

  // slt always subtracts
  assign add_sub_o  = alu_op.alt | (alu_op.func == exu_op_pkg::FN_SLT);
  assign unsigned_o = alu_op.alt;
  assign sr_arith_o = alu_op.alt;
  assign sr_right_o = (alu_op.func == exu_op_pkg::FN_SR);

  // locked result still matches the current request
  assign hit   = lock_vld & (lock_op == op_i) & (lock_src1 == src1_i) & (lock_src2 == src2_i);
  assign issue = md_en_i & ~busy & ~hit & ~flush_i;

  always_ff @(posedge clk) begin
    if (issue) begin
      lock_op   <= op_i;
      lock_src1 <= src1_i;
      lock_src2 <= src2_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q  <= 1'b0;
      busy     <= 1'b0;
      lock_vld <= 1'b0;
    end else begin
      start_q <= issue;
      if (flush_i) begin
        busy     <= 1'b0;
        lock_vld <= 1'b0;
      end else if (issue) begin
        busy     <= 1'b1;
        lock_vld <= 1'b0;
      end else if (md.mul_done | md.div_done) begin
        busy     <= 1'b0;
        lock_vld <= 1'b1;
      end
    end
  end

  // units see the md_op_t view of the locked word
  assign md.start  = start_q;
  assign md.is_div = lock_op.md.is_div;
  assign md.kind   = lock_op.md.kind;
  assign md.flush  = flush_i;
  assign md.src1   = lock_src1;
  assign md.src2   = lock_src2;

  assign md_res = lock_op.md.is_div ? md.div_res : md.mul_res;

  always_comb begin
    unique case (alu_op.func)
      exu_op_pkg::FN_ADD:  alu_res = sum_i;
      exu_op_pkg::FN_SLL:  alu_res = shift_i;
      exu_op_pkg::FN_SLT:  alu_res = {{(rv_data_pkg::XLEN-1){1'b0}}, less_i};
      exu_op_pkg::FN_PASS: alu_res = src2_i;
      exu_op_pkg::FN_XOR:  alu_res = src1_i ^ src2_i;
      exu_op_pkg::FN_SR:   alu_res = shift_i;
      exu_op_pkg::FN_OR:   alu_res = src1_i | src2_i;
      exu_op_pkg::FN_AND:  alu_res = src1_i & src2_i;
    endcase
  end

  always_comb begin
    if (md_en_i) begin
      result_o = md_res;
    end else if (alu_op.word) begin
      result_o = {{(rv_data_pkg::XLEN-rv_data_pkg::WLEN){alu_res[rv_data_pkg::WLEN-1]}},
                  alu_res[rv_data_pkg::WLEN-1:0]};
    end else begin
      result_o = alu_res;
    end
  end

  // stall until the locked request has its result
  assign not_ok_o = md_en_i & ~hit;

endmodule

`default_nettype wire

/* verilog/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit (
  input  wire logic clk,
  input  wire logic rst_n,
  md_if.div         md
);

  logic                            run;
  logic                            fix;
  logic [rv_data_pkg::SHAMT_W-1:0] cnt;
  logic                            go;
  logic                            is_sgn;
  logic                            a_neg;
  logic                            b_neg;
  logic [rv_data_pkg::XLEN-1:0]    a_mag;
  logic [rv_data_pkg::XLEN-1:0]    b_mag;
  exu_op_pkg::md_kind_e            kind_q;
  logic                            q_neg;
  logic                            r_neg;
  logic                            dz;
  logic [rv_data_pkg::XLEN-1:0]    dvd_raw;
  logic [rv_data_pkg::XLEN-1:0]    dvs;
  logic [rv_data_pkg::XLEN-1:0]    quo;
  logic [rv_data_pkg::XLEN-1:0]    rem;
  logic [rv_data_pkg::XLEN:0]      r_sh;
  logic [rv_data_pkg::XLEN:0]      diff;
  logic                            ge;
  logic [rv_data_pkg::XLEN-1:0]    q_fix;
  logic [rv_data_pkg::XLEN-1:0]    r_fix;

  assign go = md.start & md.is_div & ~run & ~fix & ~md.flush;

  assign is_sgn = (md.kind == exu_op_pkg::DIV) | (md.kind == exu_op_pkg::REM);
  assign a_neg  = is_sgn & md.src1[rv_data_pkg::XLEN-1];
  assign b_neg  = is_sgn & md.src2[rv_data_pkg::XLEN-1];
  assign a_mag  = a_neg ? -md.src1 : md.src1;
  assign b_mag  = b_neg ? -md.src2 : md.src2;

  // one restoring step, dividend bits shift in from quo
  assign r_sh = {rem, quo[rv_data_pkg::XLEN-1]};
  assign ge   = r_sh >= {1'b0, dvs};
  assign diff = r_sh - {1'b0, dvs};

  // remainder takes the dividend sign
  // min / -1 needs no special case, the magnitude 2^63 negates back to min
  assign q_fix = dz ? '1 : (q_neg ? -quo : quo);
  assign r_fix = dz ? dvd_raw : (r_neg ? -rem : rem);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run         <= 1'b0;
      fix         <= 1'b0;
      cnt         <= '0;
      md.div_done <= 1'b0;
    end else begin
      md.div_done <= 1'b0;
      if (md.flush) begin
        run <= 1'b0;
        fix <= 1'b0;
      end else if (go) begin
        run <= 1'b1;
        cnt <= '0;
      end else if (run) begin
        cnt <= cnt + 1'b1;
        if (cnt == '1) begin
          run <= 1'b0;
          fix <= 1'b1;
        end
      end else if (fix) begin
        fix         <= 1'b0;
        md.div_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      quo     <= a_mag;
      dvs     <= b_mag;
      rem     <= '0;
      q_neg   <= a_neg ^ b_neg;
      r_neg   <= a_neg;
      dz      <= (md.src2 == '0);
      dvd_raw <= md.src1;
      kind_q  <= md.kind;
    end else if (run & ~md.flush) begin
      quo <= {quo[rv_data_pkg::XLEN-2:0], ge};
      rem <= ge ? diff[rv_data_pkg::XLEN-1:0] : r_sh[rv_data_pkg::XLEN-1:0];
    end else if (fix & ~md.flush) begin
      unique case (kind_q)
        exu_op_pkg::DIV, exu_op_pkg::DIVU: md.div_res <= q_fix;
        exu_op_pkg::REM, exu_op_pkg::REMU: md.div_res <= r_fix;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
  input  wire logic clk,
  input  wire logic rst_n,
  md_if.mul         md
);

  logic                            busy;
  logic [rv_data_pkg::SHAMT_W-1:0] cnt;
  logic                            go;
  logic                            step;
  logic                            a_sgn;
  logic                            b_sgn;
  logic                            a_neg;
  logic                            b_neg;
  logic [rv_data_pkg::XLEN-1:0]    a_mag;
  logic [rv_data_pkg::XLEN-1:0]    b_mag;
  logic                            neg;
  exu_op_pkg::md_kind_e            kind_q;
  logic [rv_data_pkg::XLEN-1:0]    mcand;
  logic [rv_data_pkg::XLEN:0]      part;
  logic [2*rv_data_pkg::XLEN-1:0]  acc;
  logic [2*rv_data_pkg::XLEN-1:0]  acc_nxt;
  logic [2*rv_data_pkg::XLEN-1:0]  prod;

  assign go   = md.start & ~md.is_div & ~busy & ~md.flush;
  assign step = busy & ~md.flush;

  always_comb begin
    unique case (md.kind)
      exu_op_pkg::MULH: begin
        a_sgn = 1'b1;
        b_sgn = 1'b1;
      end
      exu_op_pkg::MULHSU: begin
        a_sgn = 1'b1;
        b_sgn = 1'b0;
      end
      // low half does not depend on signedness
      exu_op_pkg::MUL, exu_op_pkg::MULHU: begin
        a_sgn = 1'b0;
        b_sgn = 1'b0;
      end
    endcase
  end

  assign a_neg = a_sgn & md.src1[rv_data_pkg::XLEN-1];
  assign b_neg = b_sgn & md.src2[rv_data_pkg::XLEN-1];
  assign a_mag = a_neg ? -md.src1 : md.src1;
  assign b_mag = b_neg ? -md.src2 : md.src2;

  // upper half accumulates, lower half shifts the multiplier out
  assign part    = {1'b0, acc[2*rv_data_pkg::XLEN-1:rv_data_pkg::XLEN]} +
                   (acc[0] ? {1'b0, mcand} : '0);
  assign acc_nxt = {part, acc[rv_data_pkg::XLEN-1:1]};
  assign prod    = neg ? -acc_nxt : acc_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      cnt         <= '0;
      md.mul_done <= 1'b0;
    end else begin
      md.mul_done <= 1'b0;
      if (md.flush) begin
        busy <= 1'b0;
        cnt  <= '0;
      end else if (go) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == '1) begin
          busy        <= 1'b0;
          md.mul_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      mcand  <= a_mag;
      acc    <= {{rv_data_pkg::XLEN{1'b0}}, b_mag};
      neg    <= a_neg ^ b_neg;
      kind_q <= md.kind;
    end else if (step) begin
      acc <= acc_nxt;
      if (cnt == '1) begin
        md.mul_res <= (kind_q == exu_op_pkg::MUL) ? prod[rv_data_pkg::XLEN-1:0] :
                      prod[2*rv_data_pkg::XLEN-1:rv_data_pkg::XLEN];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
  input  wire logic [rv_data_pkg::XLEN-1:0]    src1_i,
  input  wire logic [rv_data_pkg::SHAMT_W-1:0] shamt_i,
  input  wire logic                            word_i,
  input  wire logic                            right_i,
  input  wire logic                            arith_i,
  output logic [rv_data_pkg::XLEN-1:0]         shift_o
);

  logic [rv_data_pkg::XLEN-1:0]    sh_src;
  logic [rv_data_pkg::XLEN-1:0]    sh_out;
  logic [rv_data_pkg::XLEN-1:0]    fill_mask;
  logic [rv_data_pkg::SHAMT_W-1:0] amt;
  logic                            sign_bit;
  logic                            fill;

  function automatic logic [rv_data_pkg::XLEN-1:0] bit_rev(
    input logic [rv_data_pkg::XLEN-1:0] v
  );
    logic [rv_data_pkg::XLEN-1:0] r;
    for (int i = 0; i < rv_data_pkg::XLEN; i++) begin
      r[i] = v[rv_data_pkg::XLEN-1-i];
    end
    return r;
  endfunction

  // word forms take the sign from bit 31
  assign sign_bit = word_i ? src1_i[rv_data_pkg::WLEN-1] : src1_i[rv_data_pkg::XLEN-1];
  assign fill     = right_i & arith_i & sign_bit;

  // word forms only use shamt[4:0]
  assign amt = word_i ? {1'b0, shamt_i[rv_data_pkg::SHAMT_W-2:0]} : shamt_i;

  // left shift is a right shift of the reversed source
  assign sh_src = !right_i ? bit_rev(src1_i) :
                  word_i   ? {{rv_data_pkg::WLEN{fill}}, src1_i[rv_data_pkg::WLEN-1:0]} :
                             src1_i;

  assign sh_out = sh_src >> amt;

  // top amt bits, set for arithmetic fill
  assign fill_mask = ~({rv_data_pkg::XLEN{1'b1}} >> amt);

  assign shift_o = right_i ? (sh_out | (fill_mask & {rv_data_pkg::XLEN{fill}})) :
                             bit_rev(sh_out);

endmodule

`default_nettype wire

/* verilog/alu_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_adder (
  input  wire logic [rv_data_pkg::XLEN-1:0] src1_i,
  input  wire logic [rv_data_pkg::XLEN-1:0] src2_i,
  input  wire logic                         add_sub_i,
  input  wire logic                         unsigned_i,
  output logic [rv_data_pkg::XLEN-1:0]      sum_o,
  output logic                              zero_o,
  output logic                              less_o
);

  logic [rv_data_pkg::XLEN-1:0] src2_inv;
  logic [rv_data_pkg::XLEN-1:0] sum;
  logic                         carry;
  logic                         overflow;

  // sub is src1 + ~src2 + 1
  assign src2_inv = src2_i ^ {rv_data_pkg::XLEN{add_sub_i}};

  assign {carry, sum} = {1'b0, src1_i} + {1'b0, src2_inv} +
                        {{rv_data_pkg::XLEN{1'b0}}, add_sub_i};

  // same input signs, different result sign
  assign overflow = (src1_i[rv_data_pkg::XLEN-1] == src2_inv[rv_data_pkg::XLEN-1]) &&
                    (sum[rv_data_pkg::XLEN-1] != src1_i[rv_data_pkg::XLEN-1]);

  // unsigned: borrow out of the subtract
  // signed: result sign corrected by overflow
  assign less_o = unsigned_i ? (carry ^ add_sub_i) : (sum[rv_data_pkg::XLEN-1] ^ overflow);

  assign zero_o = ~|sum;
  assign sum_o  = sum;

endmodule

`default_nettype wire

/* verilog/md_if.sv */
`timescale 1ns/1ps
`default_nettype none

// request and result path between the control and the mul/div units
interface md_if;

  logic                         start;
  logic                         is_div;
  exu_op_pkg::md_kind_e         kind;
  logic                         flush;
  logic [rv_data_pkg::XLEN-1:0] src1;
  logic [rv_data_pkg::XLEN-1:0] src2;
  logic                         mul_done;
  logic                         div_done;
  logic [rv_data_pkg::XLEN-1:0] mul_res;
  logic [rv_data_pkg::XLEN-1:0] div_res;

  modport ctrl (
    output start, is_div, kind, flush, src1, src2,
    input  mul_done, div_done, mul_res, div_res
  );

  modport mul (
    input  start, is_div, kind, flush, src1, src2,
    output mul_done, mul_res
  );

  modport div (
    input  start, is_div, kind, flush, src1, src2,
    output div_done, div_res
  );

endinterface

`default_nettype wire

/* verilog/exu_op_pkg.sv */
`default_nettype none

package exu_op_pkg;

  // alu function select, same order as funct3
  typedef enum logic [2:0] {
    FN_ADD  = 3'd0,
    FN_SLL  = 3'd1,
    FN_SLT  = 3'd2,
    FN_PASS = 3'd3,
    FN_XOR  = 3'd4,
    FN_SR   = 3'd5,
    FN_OR   = 3'd6,
    FN_AND  = 3'd7
  } alu_func_e;

  // multiply meaning of the mul/div kind
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } md_kind_e;

  // divide meaning of the same codes
  localparam md_kind_e DIV  = MUL;
  localparam md_kind_e DIVU = MULH;
  localparam md_kind_e REM  = MULHSU;
  localparam md_kind_e REMU = MULHU;

  typedef struct packed {
    logic      word;
    logic      alt;
    alu_func_e func;
  } alu_op_t;

  typedef struct packed {
    logic [1:0] pad;
    logic       is_div;
    md_kind_e   kind;
  } md_op_t;

  // one op word, md_en selects which view applies
  typedef union packed {
    alu_op_t alu;
    md_op_t  md;
  } exu_op_u;

endpackage

`default_nettype wire

/* verilog/rv_data_pkg.sv */
`default_nettype none

// widths shared by the integer datapath blocks
package rv_data_pkg;

  // full register width of the core
  localparam int XLEN = 64;

  // low half used by the *w instructions,
  // results of those are sign-extended from bit WLEN-1
  localparam int WLEN = 32;

  // shift amount field of src2, also log2 of XLEN
  localparam int SHAMT_W = 6;

endpackage

`default_nettype wire
